// File: verilog.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/control_pkg.sv
hdl/step_counter.sv
hdl/control_fsm.sv
hdl/micro_decoder.sv
hdl/control_register.sv
hdl/control_top.sv
tb/control_tb.sv

// File: Makefile
# Verilator build and run of the control unit testbench

VERILATOR ?= verilator
TOP       ?= control_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/control_tb.sv
`default_nettype none

module control_tb
    import isa_pkg::*;
    import control_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_LEN       = 32;
    localparam int TIMEOUT_CYCLES = 40 * PROG_LEN + 50;

    logic     clk;
    logic     rst;
    logic     prog_load;
    word_t    ir_data = '0;
    flags_t   flags_data = '0;

    logic     mar_in;
    logic     mdr_in;
    logic     mdr_out;
    logic     pc_out;
    logic     pc_jump;
    logic     pc_increment;
    logic     tmp0_in;
    logic     tmp1_in;
    logic     alu_out;
    logic     flags_in;
    logic     reg_in;
    logic     reg_out;
    logic     ir_in;
    logic     in_out;
    logic     out_in;
    logic     bus_drive;
    reg_idx_t reg_sel;
    alu_op_t  alu_op;
    word_t    bus_out;
    logic     halt;

    strobe_t  strobes;

    word_t    program_mem [0:PROG_LEN-1];
    logic [4:0] feed_idx = '0;
    int       fetch_count = 0;
    integer   seed = 65476;
    int       cycle_count = 0;
    int       error_count = 0;

    // reference model state
    strobe_t  exp_strobes = '0;
    reg_idx_t exp_reg_sel = '0;
    alu_op_t  exp_alu_op = ALU_ADD;
    word_t    exp_bus = '0;
    logic     exp_halt = 1'b0;
    int       pos = 0; // cycle position inside the current instruction
    logic     halted = 1'b0;
    word_t    cur_instr = '0;
    logic [4:0] model_idx = '0;

    control_top control_top_inst (
        .clk          (clk),
        .rst          (rst),
        .prog_load    (prog_load),
        .ir_data      (ir_data),
        .flags_data   (flags_data),
        .mar_in       (mar_in),
        .mdr_in       (mdr_in),
        .mdr_out      (mdr_out),
        .pc_out       (pc_out),
        .pc_jump      (pc_jump),
        .pc_increment (pc_increment),
        .tmp0_in      (tmp0_in),
        .tmp1_in      (tmp1_in),
        .alu_out      (alu_out),
        .flags_in     (flags_in),
        .reg_in       (reg_in),
        .reg_out      (reg_out),
        .ir_in        (ir_in),
        .in_out       (in_out),
        .out_in       (out_in),
        .bus_drive    (bus_drive),
        .reg_sel      (reg_sel),
        .alu_op       (alu_op),
        .bus_out      (bus_out),
        .halt         (halt)
    );

    assign strobes = {bus_drive, out_in, in_out, ir_in, reg_out, reg_in, flags_in, alu_out,
                      tmp1_in, tmp0_in, pc_increment, pc_jump, pc_out, mdr_out, mdr_in, mar_in};

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        program_mem[0]  = 16'h13A5; // setn r3, 0xa5
        program_mem[1]  = 16'hB042; // jumpn 0x42
        program_mem[2]  = 16'h0703; // jump to x = 7
        program_mem[3]  = 16'h0201; // read r2
        program_mem[4]  = 16'h0502; // write r5
        program_mem[5]  = 16'h2410; // loadn r4, 0x10
        program_mem[6]  = 16'h3620; // storen r6, 0x20
        program_mem[7]  = 16'h4190; // loadr r1, [r9]
        program_mem[8]  = 16'h4281; // storer r2, [r8]
        program_mem[9]  = 16'h6123; // add
        program_mem[10] = 16'h7456; // sub
        program_mem[11] = 16'h8789; // mul
        program_mem[12] = 16'h9ABC; // div
        program_mem[13] = 16'hADEF; // mod
        program_mem[14] = 16'h5000; // unused opcode
        program_mem[15] = 16'hC1F0; // conditional jumps with three of each
        program_mem[16] = 16'hD2E1;
        program_mem[17] = 16'hE3D2;
        program_mem[18] = 16'hF4C3;
        program_mem[19] = 16'hC5B4;
        program_mem[20] = 16'hD6A5;
        program_mem[21] = 16'hE796;
        program_mem[22] = 16'hF887;
        program_mem[23] = 16'hC978;
        program_mem[24] = 16'hDA69;
        program_mem[25] = 16'hEB5A;
        program_mem[26] = 16'hFC4B;
        program_mem[27] = 16'h0000; // halt
        program_mem[28] = 16'h193C; // setn r9, 0x3c after the second reset
        program_mem[29] = 16'h7123; // sub cut short by prog_load
        program_mem[30] = 16'hF277; // jgtz
        program_mem[31] = 16'h0000; // halt
    end

    // instruction register and flags register outside the unit
    always @(posedge clk) begin
        int rnd;
        if (ir_in) begin
            ir_data     <= program_mem[feed_idx];
            feed_idx    <= feed_idx + 5'd1;
            fetch_count <= fetch_count + 1;
        end
        if (flags_in) begin
            rnd = $random(seed);
            flags_data <= rnd[2:0];
        end
    end

    function automatic int exec_len(input word_t instr);
        case (instr[15:12])
        4'd2, 4'd3, 4'd4: exec_len = 2;
        4'd6, 4'd7, 4'd8, 4'd9, 4'd10: exec_len = 3;
        4'd12, 4'd13, 4'd14, 4'd15: exec_len = 5;
        default: exec_len = 1;
        endcase
    endfunction

    // expected outputs of one execute step
    task automatic step_outputs(
        input  word_t    instr,
        input  int       s,
        input  flags_t   flags,
        output strobe_t  stb,
        output reg_idx_t sel,
        output alu_op_t  alu,
        output word_t    bus,
        output logic     stop
    );
        reg_idx_t x;
        reg_idx_t y;
        reg_idx_t z;
        logic     store;
        logic     taken;
        x = instr[11:8];
        y = instr[7:4];
        z = instr[3:0];
        store = (instr[15:12] == 4'd3) || (instr[15:12] == 4'd4 && instr[0]);
        case (instr[13:12])
        2'd0: taken = flags[1];              // jeqz
        2'd1: taken = !flags[1];             // jnez
        2'd2: taken = flags[0];              // jltz
        default: taken = !flags[0] && !flags[1];
        endcase
        stb  = '0;
        sel  = '0;
        alu  = ALU_ADD;
        bus  = '0;
        stop = 1'b0;
        case (instr[15:12])
        4'd0: begin
            case (instr[1:0])
            2'd0: stop = 1'b1;
            2'd1: begin
                stb[STB_IN_OUT] = 1'b1;
                stb[STB_REG_IN] = 1'b1;
                sel = x;
            end
            2'd2: begin
                stb[STB_OUT_IN]  = 1'b1;
                stb[STB_REG_OUT] = 1'b1;
                sel = x;
            end
            default: begin
                stb[STB_PC_JUMP]   = 1'b1;
                stb[STB_BUS_DRIVE] = 1'b1;
                bus = {12'h000, x};
            end
            endcase
        end
        4'd1: begin
            stb[STB_REG_IN]    = 1'b1;
            stb[STB_BUS_DRIVE] = 1'b1;
            sel = x;
            bus = {8'h00, instr[7:0]};
        end
        4'd2, 4'd3, 4'd4: begin
            if (s == 0) begin
                stb[STB_MAR_IN] = 1'b1;
                if (instr[15:12] == 4'd4) begin
                    stb[STB_REG_OUT] = 1'b1;
                    sel = y;
                end
                else begin
                    stb[STB_BUS_DRIVE] = 1'b1;
                    bus = {8'h00, instr[7:0]};
                end
            end
            else begin
                stb[STB_MDR_IN]  = store;
                stb[STB_REG_OUT] = store;
                stb[STB_MDR_OUT] = !store;
                stb[STB_REG_IN]  = !store;
                sel = x;
            end
        end
        4'd6, 4'd7, 4'd8, 4'd9, 4'd10: begin
            if (s == 0) begin
                stb[STB_TMP0_IN] = 1'b1;
                stb[STB_REG_OUT] = 1'b1;
                sel = (instr[15:12] == 4'd7) ? y : z; // sub takes y first
            end
            else if (s == 1) begin
                stb[STB_TMP1_IN] = 1'b1;
                stb[STB_REG_OUT] = 1'b1;
                sel = (instr[15:12] == 4'd7) ? z : y;
            end
            else begin
                stb[STB_ALU_OUT] = 1'b1;
                stb[STB_REG_IN]  = 1'b1;
                sel = x;
                case (instr[15:12])
                4'd7: alu = ALU_SUB;
                4'd8: alu = ALU_MUL;
                4'd9: alu = ALU_DIV;
                4'd10: alu = ALU_MOD;
                default: alu = ALU_ADD;
                endcase
            end
        end
        4'd11: begin
            stb[STB_PC_JUMP]   = 1'b1;
            stb[STB_BUS_DRIVE] = 1'b1;
            bus = {8'h00, instr[7:0]};
        end
        4'd12, 4'd13, 4'd14, 4'd15: begin
            case (s)
            0: begin
                stb[STB_TMP0_IN] = 1'b1;
                stb[STB_REG_OUT] = 1'b1;
                sel = x;
            end
            1: begin
                stb[STB_TMP1_IN]   = 1'b1;
                stb[STB_BUS_DRIVE] = 1'b1; // zero onto the bus
            end
            2: stb[STB_FLAGS_IN] = 1'b1;
            3: ;
            default: begin
                stb[STB_PC_JUMP]   = taken;
                stb[STB_BUS_DRIVE] = taken;
                bus = taken ? {8'h00, instr[7:0]} : 16'h0000;
            end
            endcase
        end
        default: ;
        endcase
    endtask

    // predicts the outputs of the cycle that starts at this edge
    always @(posedge clk) begin
        strobe_t  stb;
        reg_idx_t sel;
        alu_op_t  alu;
        word_t    bus;
        logic     stop;
        stb  = '0;
        sel  = '0;
        alu  = ALU_ADD;
        bus  = '0;
        stop = 1'b0;
        if (exp_strobes[STB_IR_IN]) begin
            cur_instr = program_mem[model_idx];
            model_idx = model_idx + 5'd1;
        end
        if (rst) begin
            pos      = 0;
            halted   = 1'b0;
            exp_halt <= 1'b0;
        end
        else if (prog_load && !halted) begin
            pos = 0;
        end
        else if (!halted) begin
            case (pos)
            0: begin
                stb[STB_PC_OUT] = 1'b1;
                stb[STB_MAR_IN] = 1'b1;
                pos = 1;
            end
            1: begin
                stb[STB_MDR_OUT]      = 1'b1;
                stb[STB_IR_IN]        = 1'b1;
                stb[STB_PC_INCREMENT] = 1'b1;
                pos = 2;
            end
            2: pos = 3; // ir settles
            default: begin
                step_outputs(cur_instr, pos - 3, flags_data, stb, sel, alu, bus, stop);
                pos = (pos - 2 == exec_len(cur_instr)) ? 0 : pos + 1;
                if (stop) begin
                    halted   = 1'b1;
                    exp_halt <= 1'b1;
                end
            end
            endcase
        end
        exp_strobes <= stb;
        exp_reg_sel <= sel;
        exp_alu_op  <= alu;
        exp_bus     <= bus;
    end

    strobes_a: assert property (@(posedge clk) disable iff (rst) strobes == exp_strobes)
        else begin
            error_count = error_count + 1;
            $display("FAIL %0t strobes expected %h got %h", $time,
                     $sampled(exp_strobes), $sampled(strobes));
        end

    halt_a: assert property (@(posedge clk) disable iff (rst) halt == exp_halt)
        else begin
            error_count = error_count + 1;
            $display("FAIL %0t halt expected %b got %b", $time,
                     $sampled(exp_halt), $sampled(halt));
        end

    bus_a: assert property (@(posedge clk) disable iff (rst)
        exp_strobes[STB_BUS_DRIVE] |-> bus_out == exp_bus)
        else begin
            error_count = error_count + 1;
            $display("FAIL %0t bus_out expected %h got %h", $time,
                     $sampled(exp_bus), $sampled(bus_out));
        end

    reg_sel_a: assert property (@(posedge clk) disable iff (rst)
        (exp_strobes[STB_REG_IN] || exp_strobes[STB_REG_OUT]) |-> reg_sel == exp_reg_sel)
        else begin
            error_count = error_count + 1;
            $display("FAIL %0t reg_sel expected %h got %h", $time,
                     $sampled(exp_reg_sel), $sampled(reg_sel));
        end

    alu_op_a: assert property (@(posedge clk) disable iff (rst)
        (exp_strobes[STB_ALU_OUT] || exp_strobes[STB_FLAGS_IN]) |-> alu_op == exp_alu_op)
        else begin
            error_count = error_count + 1;
            $display("FAIL %0t alu_op expected %0d got %0d", $time,
                     $sampled(exp_alu_op), $sampled(alu_op));
        end

    bus_source_a: assert property (@(posedge clk) disable iff (rst)
        $onehot0({pc_out, mdr_out, reg_out, alu_out, in_out, bus_drive}))
        else begin
            error_count = error_count + 1;
            $display("more than one bus source drove the bus at %0t", $time);
        end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without reaching the end", cycle_count);
            $display("errors=%0d instructions=%0d cycles=%0d", error_count, fetch_count,
                     cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        rst       = 1'b1;
        prog_load = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        while (!halt) @(posedge clk); // first program section
        repeat (8) @(posedge clk);
        prog_load <= 1'b1; // halt must survive the loader
        repeat (3) @(posedge clk);
        prog_load <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        while (!tmp0_in) @(posedge clk);
        prog_load <= 1'b1; // cut the sub short
        repeat (2) @(posedge clk);
        prog_load <= 1'b0;
        while (!halt) @(posedge clk);
        repeat (5) @(posedge clk);
        $display("errors=%0d instructions=%0d cycles=%0d", error_count, fetch_count,
                 cycle_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end
        else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/control_top.sv
`default_nettype none

module control_top
    import isa_pkg::*;
    import control_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         prog_load,
    input  wire word_t  ir_data,
    input  wire flags_t flags_data,

    output logic        mar_in,
    output logic        mdr_in,
    output logic        mdr_out,
    output logic        pc_out,
    output logic        pc_jump,
    output logic        pc_increment,
    output logic        tmp0_in,
    output logic        tmp1_in,
    output logic        alu_out,
    output logic        flags_in,
    output logic        reg_in,
    output logic        reg_out,
    output logic        ir_in,
    output logic        in_out,
    output logic        out_in,
    output logic        bus_drive,
    output reg_idx_t    reg_sel,
    output alu_op_t     alu_op,
    output word_t       bus_out,
    output logic        halt
);

    phase_t     phase;
    logic       step_clear;
    step_t      step;
    strobe_t    next_strobes;
    reg_idx_t   next_reg_sel;
    logic       sel_valid;
    alu_op_t    next_alu_op;
    const_sel_t next_const;
    logic       last_step;
    logic       halt_req;

    control_fsm control_fsm_inst (
        .clk        (clk),
        .rst        (rst),
        .prog_load  (prog_load),
        .last_step  (last_step),
        .halt_req   (halt_req),
        .phase      (phase),
        .step_clear (step_clear)
    );

    step_counter step_counter_inst (
        .clk        (clk),
        .rst        (rst),
        .step_clear (step_clear),
        .phase      (phase),
        .step       (step)
    );

    micro_decoder micro_decoder_inst (
        .phase        (phase),
        .step         (step),
        .ir_data      (ir_data),
        .flags_data   (flags_data),
        .next_strobes (next_strobes),
        .next_reg_sel (next_reg_sel),
        .sel_valid    (sel_valid),
        .next_alu_op  (next_alu_op),
        .next_const   (next_const),
        .last_step    (last_step),
        .halt_req     (halt_req)
    );

    control_register control_register_inst (
        .clk          (clk),
        .rst          (rst),
        .prog_load    (prog_load),
        .next_strobes (next_strobes),
        .next_reg_sel (next_reg_sel),
        .sel_valid    (sel_valid),
        .next_alu_op  (next_alu_op),
        .next_const   (next_const),
        .halt_req     (halt_req),
        .ir_data      (ir_data),
        .mar_in       (mar_in),
        .mdr_in       (mdr_in),
        .mdr_out      (mdr_out),
        .pc_out       (pc_out),
        .pc_jump      (pc_jump),
        .pc_increment (pc_increment),
        .tmp0_in      (tmp0_in),
        .tmp1_in      (tmp1_in),
        .alu_out      (alu_out),
        .flags_in     (flags_in),
        .reg_in       (reg_in),
        .reg_out      (reg_out),
        .ir_in        (ir_in),
        .in_out       (in_out),
        .out_in       (out_in),
        .bus_drive    (bus_drive),
        .reg_sel      (reg_sel),
        .alu_op       (alu_op),
        .bus_out      (bus_out),
        .halt         (halt)
    );

endmodule

`default_nettype wire

// File: hdl/control_register.sv
`default_nettype none

module control_register
    import isa_pkg::*;
    import control_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             prog_load,
    input  wire strobe_t    next_strobes,
    input  wire reg_idx_t   next_reg_sel,
    input  wire             sel_valid,
    input  wire alu_op_t    next_alu_op,
    input  wire const_sel_t next_const,
    input  wire             halt_req,
    input  wire word_t      ir_data,

    output logic            mar_in,
    output logic            mdr_in,
    output logic            mdr_out,
    output logic            pc_out,
    output logic            pc_jump,
    output logic            pc_increment,
    output logic            tmp0_in,
    output logic            tmp1_in,
    output logic            alu_out,
    output logic            flags_in,
    output logic            reg_in,
    output logic            reg_out,
    output logic            ir_in,
    output logic            in_out,
    output logic            out_in,
    output logic            bus_drive,
    output reg_idx_t        reg_sel,
    output alu_op_t         alu_op,
    output word_t           bus_out,
    output logic            halt
);

    strobe_t  strobes_q;
    imm_t     imm;
    reg_idx_t reg_x;

    assign imm   = ir_data[7:0];
    assign reg_x = ir_data[11:8];

    always_ff @(posedge clk) begin
        if (rst || prog_load) begin
            strobes_q <= '0; // silent while the program loads
        end
        else begin
            strobes_q <= next_strobes;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_sel <= '0;
            alu_op  <= ALU_ADD;
            halt    <= 1'b0;
        end
        else begin
            if (sel_valid) begin
                reg_sel <= next_reg_sel;
            end
            if (next_strobes[STB_ALU_OUT] || next_strobes[STB_FLAGS_IN]) begin
                alu_op <= next_alu_op;
            end
            if (halt_req && !prog_load) begin
                halt <= 1'b1; // sticky until rst
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_out <= '0;
        end
        else begin
            case (next_const)
            CONST_IMM_ZX:  bus_out <= word_t'(imm);
            CONST_REGX_ZX: bus_out <= word_t'(reg_x);
            default:       bus_out <= '0; // zero constant or idle
            endcase
        end
    end

    assign mar_in       = strobes_q[STB_MAR_IN];
    assign mdr_in       = strobes_q[STB_MDR_IN];
    assign mdr_out      = strobes_q[STB_MDR_OUT];
    assign pc_out       = strobes_q[STB_PC_OUT];
    assign pc_jump      = strobes_q[STB_PC_JUMP];
    assign pc_increment = strobes_q[STB_PC_INCREMENT];
    assign tmp0_in      = strobes_q[STB_TMP0_IN];
    assign tmp1_in      = strobes_q[STB_TMP1_IN];
    assign alu_out      = strobes_q[STB_ALU_OUT];
    assign flags_in     = strobes_q[STB_FLAGS_IN];
    assign reg_in       = strobes_q[STB_REG_IN];
    assign reg_out      = strobes_q[STB_REG_OUT];
    assign ir_in        = strobes_q[STB_IR_IN];
    assign in_out       = strobes_q[STB_IN_OUT];
    assign out_in       = strobes_q[STB_OUT_IN];
    assign bus_drive    = strobes_q[STB_BUS_DRIVE];

    // the external bus merge expects a single driver per cycle
    one_bus_source_a: assert property (@(posedge clk) disable iff (rst)
        $onehot0({pc_out, mdr_out, reg_out, alu_out, in_out, bus_drive}))
        else $error("more than one bus source active");

endmodule

`default_nettype wire

// File: hdl/micro_decoder.sv
`default_nettype none

module micro_decoder
    import isa_pkg::*;
    import control_pkg::*;
(
    input  wire phase_t phase,
    input  wire step_t  step,
    input  wire word_t  ir_data,
    input  wire flags_t flags_data,
    output strobe_t     next_strobes,
    output reg_idx_t    next_reg_sel,
    output logic        sel_valid,
    output alu_op_t     next_alu_op,
    output const_sel_t  next_const,
    output logic        last_step,
    output logic        halt_req
);

    opcode_t  op;
    reg_idx_t reg_x;
    reg_idx_t reg_y;
    reg_idx_t reg_z;
    logic     is_store;
    logic     take_branch;
    alu_op_t  group_op;

    assign op    = opcode_t'(ir_data[15:12]);
    assign reg_x = ir_data[11:8];
    assign reg_y = ir_data[7:4];
    assign reg_z = ir_data[3:0];

    // storen, or storer when sub-code bit 0 is set
    assign is_store = (op == OP_STOREN) || (op == OP_MEMR && ir_data[0]);

    always_comb begin
        case (op)
        OP_JEQZ: take_branch = flags_data[FLAG_ZERO];
        OP_JNEZ: take_branch = !flags_data[FLAG_ZERO];
        OP_JLTZ: take_branch = flags_data[FLAG_SIGN];
        OP_JGTZ: take_branch = !flags_data[FLAG_SIGN] && !flags_data[FLAG_ZERO];
        default: take_branch = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
        OP_SUB:  group_op = ALU_SUB;
        OP_MUL:  group_op = ALU_MUL;
        OP_DIV:  group_op = ALU_DIV;
        OP_MOD:  group_op = ALU_MOD;
        default: group_op = ALU_ADD; // add, copy, nop
        endcase
    end

    always_comb begin
        next_strobes = '0;
        next_reg_sel = '0;
        next_alu_op  = ALU_ADD;
        next_const   = CONST_NONE;
        last_step    = 1'b0;
        halt_req     = 1'b0;
        case (phase)
        FETCH_ADDR: begin
            next_strobes[STB_PC_OUT] = 1'b1;
            next_strobes[STB_MAR_IN] = 1'b1;
        end
        FETCH_DATA: begin
            next_strobes[STB_MDR_OUT]      = 1'b1;
            next_strobes[STB_IR_IN]        = 1'b1;
            next_strobes[STB_PC_INCREMENT] = 1'b1;
        end
        EXECUTE: begin
            case (op)
            OP_SYS: begin
                last_step = 1'b1;
                case (ir_data[1:0])
                2'b00: halt_req = 1'b1;
                2'b01: begin // read
                    next_strobes[STB_IN_OUT] = 1'b1;
                    next_strobes[STB_REG_IN] = 1'b1;
                    next_reg_sel = reg_x;
                end
                2'b10: begin // write
                    next_strobes[STB_OUT_IN]  = 1'b1;
                    next_strobes[STB_REG_OUT] = 1'b1;
                    next_reg_sel = reg_x;
                end
                default: begin // jump to x field
                    next_strobes[STB_PC_JUMP] = 1'b1;
                    next_const = CONST_REGX_ZX;
                end
                endcase
            end
            OP_SETN: begin
                last_step = 1'b1;
                next_strobes[STB_REG_IN] = 1'b1;
                next_reg_sel = reg_x;
                next_const   = CONST_IMM_ZX;
            end
            OP_LOADN, OP_STOREN, OP_MEMR: begin
                if (step == '0) begin
                    next_strobes[STB_MAR_IN] = 1'b1;
                    if (op == OP_MEMR) begin
                        next_strobes[STB_REG_OUT] = 1'b1; // address from y
                        next_reg_sel = reg_y;
                    end
                    else begin
                        next_const = CONST_IMM_ZX;
                    end
                end
                else begin
                    last_step    = 1'b1;
                    next_reg_sel = reg_x;
                    next_strobes[STB_MDR_IN]  = is_store;
                    next_strobes[STB_REG_OUT] = is_store;
                    next_strobes[STB_MDR_OUT] = !is_store;
                    next_strobes[STB_REG_IN]  = !is_store;
                end
            end
            OP_ADD, OP_SUB, OP_MUL, OP_DIV, OP_MOD: begin
                case (step)
                3'd0: begin
                    next_strobes[STB_TMP0_IN] = 1'b1;
                    next_strobes[STB_REG_OUT] = 1'b1;
                    next_reg_sel = (op == OP_SUB) ? reg_y : reg_z; // sub swaps operands
                end
                3'd1: begin
                    next_strobes[STB_TMP1_IN] = 1'b1;
                    next_strobes[STB_REG_OUT] = 1'b1;
                    next_reg_sel = (op == OP_SUB) ? reg_z : reg_y;
                end
                default: begin
                    last_step = 1'b1;
                    next_strobes[STB_ALU_OUT] = 1'b1;
                    next_strobes[STB_REG_IN]  = 1'b1;
                    next_reg_sel = reg_x;
                    next_alu_op  = group_op;
                end
                endcase
            end
            OP_JUMPN: begin
                last_step = 1'b1;
                next_strobes[STB_PC_JUMP] = 1'b1;
                next_const = CONST_IMM_ZX;
            end
            OP_JEQZ, OP_JNEZ, OP_JLTZ, OP_JGTZ: begin
                case (step)
                3'd0: begin
                    next_strobes[STB_TMP0_IN] = 1'b1;
                    next_strobes[STB_REG_OUT] = 1'b1;
                    next_reg_sel = reg_x;
                end
                3'd1: begin
                    next_strobes[STB_TMP1_IN] = 1'b1;
                    next_const = CONST_ZERO;
                end
                3'd2: next_strobes[STB_FLAGS_IN] = 1'b1; // x + 0 sets the flags
                3'd3: ; // flags register loads here
                default: begin
                    last_step = 1'b1;
                    next_strobes[STB_PC_JUMP] = take_branch;
                    next_const = take_branch ? CONST_IMM_ZX : CONST_NONE;
                end
                endcase
            end
            default: last_step = 1'b1; // opcode 5
            endcase
        end
        default: ; // fetch wait and halted are silent
        endcase
        next_strobes[STB_BUS_DRIVE] = (next_const != CONST_NONE);
        sel_valid = next_strobes[STB_REG_IN] || next_strobes[STB_REG_OUT];
    end

endmodule

`default_nettype wire

// File: hdl/control_fsm.sv
`default_nettype none

module control_fsm
    import control_pkg::*;
(
    input  wire  clk,
    input  wire  rst,
    input  wire  prog_load,
    input  wire  last_step,
    input  wire  halt_req,
    output phase_t phase,
    output logic step_clear
);

    phase_t phase_nxt;

    always_comb begin
        phase_nxt = phase;
        case (phase)
        FETCH_ADDR: phase_nxt = FETCH_DATA;
        FETCH_DATA: phase_nxt = FETCH_WAIT;
        FETCH_WAIT: phase_nxt = EXECUTE;
        EXECUTE: begin
            if (last_step) begin
                phase_nxt = halt_req ? HALTED : FETCH_ADDR;
            end
        end
        default: phase_nxt = HALTED; // only rst gets out
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= FETCH_ADDR;
        end
        else if (prog_load && phase != HALTED) begin
            phase <= FETCH_ADDR; // loader owns the bus
        end
        else begin
            phase <= phase_nxt;
        end
    end

    // counter restarts at every instruction boundary
    assign step_clear = prog_load || (phase == EXECUTE && last_step);

    halted_sticky_a: assert property (@(posedge clk) disable iff (rst)
        phase == HALTED |=> phase == HALTED)
        else $error("left HALTED without reset");

endmodule

`default_nettype wire

// File: hdl/step_counter.sv
`default_nettype none

module step_counter
    import control_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         step_clear,
    input  wire phase_t phase,
    output step_t       step
);

    always_ff @(posedge clk) begin
        if (rst || step_clear) begin
            step <= '0;
        end
        else if (phase == EXECUTE) begin
            step <= step + 1'b1; // one micro-step per cycle
        end
    end

    // longest microcode (conditional jump) ends at step 4
    step_range_a: assert property (@(posedge clk) disable iff (rst) step <= 3'd4)
        else $error("step counter ran past 4");

endmodule

`default_nettype wire

// File: hdl/control_pkg.sv
`default_nettype none

`include "control_config.svh"

package control_pkg;

    typedef enum logic [2:0] {
        FETCH_ADDR,
        FETCH_DATA,
        FETCH_WAIT, // ir settles after ir_in
        EXECUTE,
        HALTED
    } phase_t;

    typedef logic [`CTRL_STEP_W-1:0] step_t;

    typedef logic [15:0] strobe_t;

    localparam int unsigned STB_MAR_IN       = 0;
    localparam int unsigned STB_MDR_IN       = 1;
    localparam int unsigned STB_MDR_OUT      = 2;
    localparam int unsigned STB_PC_OUT       = 3;
    localparam int unsigned STB_PC_JUMP      = 4;
    localparam int unsigned STB_PC_INCREMENT = 5;
    localparam int unsigned STB_TMP0_IN      = 6;
    localparam int unsigned STB_TMP1_IN      = 7;
    localparam int unsigned STB_ALU_OUT      = 8;
    localparam int unsigned STB_FLAGS_IN     = 9;
    localparam int unsigned STB_REG_IN       = 10;
    localparam int unsigned STB_REG_OUT      = 11;
    localparam int unsigned STB_IR_IN        = 12;
    localparam int unsigned STB_IN_OUT       = 13;
    localparam int unsigned STB_OUT_IN       = 14;
    localparam int unsigned STB_BUS_DRIVE    = 15; // unit drives bus_out

    // value placed on bus_out
    typedef enum logic [1:0] {
        CONST_NONE,
        CONST_IMM_ZX,
        CONST_REGX_ZX,
        CONST_ZERO
    } const_sel_t;

endpackage

`default_nettype wire

// File: hdl/isa_pkg.sv
`default_nettype none

`include "control_config.svh"

package isa_pkg;

    typedef logic [`CTRL_DATA_W-1:0] word_t;

    // instruction groups in bits 15..12 with 5 unused
    typedef enum logic [3:0] {
        OP_SYS    = 4'd0, // halt, read, write, jump
        OP_SETN   = 4'd1,
        OP_LOADN  = 4'd2,
        OP_STOREN = 4'd3,
        OP_MEMR   = 4'd4, // loadr, storer
        OP_ADD    = 4'd6, // also copy and nop
        OP_SUB    = 4'd7, // also neg
        OP_MUL    = 4'd8,
        OP_DIV    = 4'd9,
        OP_MOD    = 4'd10,
        OP_JUMPN  = 4'd11,
        OP_JEQZ   = 4'd12,
        OP_JNEZ   = 4'd13,
        OP_JLTZ   = 4'd14,
        OP_JGTZ   = 4'd15
    } opcode_t;

    typedef enum logic [`CTRL_ALU_W-1:0] {
        ALU_ADD = 0,
        ALU_SUB = 1,
        ALU_MUL = 2,
        ALU_DIV = 3,
        ALU_MOD = 4
    } alu_op_t;

    typedef logic [`CTRL_REG_W-1:0] reg_idx_t;
    typedef logic [`CTRL_IMM_W-1:0] imm_t;

    // carry in bit 2 is not used by the branch rule
    typedef logic [2:0] flags_t;

    localparam int unsigned FLAG_ZERO = 1;
    localparam int unsigned FLAG_SIGN = 0;

endpackage

`default_nettype wire

// File: hdl/control_config.svh
`ifndef CONTROL_CONFIG_SVH
`define CONTROL_CONFIG_SVH

// datapath bus and instruction word
`define CTRL_DATA_W 16

// immediate field in the low byte of the instruction
`define CTRL_IMM_W 8

// one register field (x, y or z)
`define CTRL_REG_W 4

// micro-step count inside execute (up to 5 steps)
`define CTRL_STEP_W 3

// ALU operation select
`define CTRL_ALU_W 3

`endif
